/* design/zynq_shell_pkg.sv */
package zynq_shell_pkg;

   // word widths of the ARM register port, the GP1 window and the processor side
   localparam int unsigned axil_data_width_lp = 32;
   localparam int unsigned host_addr_width_lp = 30;
   localparam int unsigned bp_addr_width_lp   = 32;

   // the register map is eight words deep
   localparam int unsigned csr_addr_width_lp = 3;

   // 128 profiler regions of 8 MiB each, covering the low 1 GiB of the address
   localparam int unsigned region_width_lp = 7;
   localparam int unsigned bank_width_lp   = 32;
   localparam int unsigned num_banks_lp    = 4;
   localparam int unsigned region_lsb_lp   = 23;

   typedef logic [axil_data_width_lp-1:0] axil_data_t;

   // the GP1 port drops the top two address bits before they reach the fabric
   typedef logic [host_addr_width_lp-1:0] host_addr_t;

   typedef logic [bp_addr_width_lp-1:0]   bp_addr_t;
   typedef logic [csr_addr_width_lp-1:0]  csr_addr_t;
   typedef logic [region_width_lp-1:0]    region_idx_t;
   typedef logic [bank_width_lp-1:0]      bank_hits_t;

   // DRAM starts here in the processor's physical map
   localparam bp_addr_t bp_dram_base_lp = 32'h8000_0000;

   // 120 MiB, anything at or past this offset is outside the allocation
   localparam bp_addr_t dram_limit_lp = 32'h0780_0000;

   // register map, in words
   // 0 holds the core reset in bit 0, low keeps the core in reset
   // 1 is set by software once the DRAM window is allocated
   // 2 is the physical base of that window on the ARM side
   // 3 to 6 return the profiler banks and are read only
   localparam csr_addr_t csr_reset_lp      = 3'd0;
   localparam csr_addr_t csr_dram_alloc_lp = 3'd1;
   localparam csr_addr_t csr_dram_base_lp  = 3'd2;
   localparam csr_addr_t csr_prof0_lp      = 3'd3;

endpackage

/* design/shell_csr_file.sv */
module shell_csr_file
  (input  logic                                                         aclk_i
   , input  logic                                                       rst_n_i

   , input  logic                                                       csr_wr_v_i
   , input  zynq_shell_pkg::csr_addr_t                                  csr_wr_addr_i
   , input  zynq_shell_pkg::axil_data_t                                 csr_wr_data_i

   , input  logic                                                       csr_rd_v_i
   , input  zynq_shell_pkg::csr_addr_t                                  csr_rd_addr_i
   , output zynq_shell_pkg::axil_data_t                                 csr_rd_data_o
   , output logic                                                       csr_rd_v_o

   , input  zynq_shell_pkg::bank_hits_t [zynq_shell_pkg::num_banks_lp-1:0] prof_words_i

   , output zynq_shell_pkg::bp_addr_t                                   dram_base_o
   , output logic                                                       core_reset_o
   );

   zynq_shell_pkg::axil_data_t reset_r;
   zynq_shell_pkg::axil_data_t alloc_r;
   zynq_shell_pkg::axil_data_t base_r;

   zynq_shell_pkg::axil_data_t rd_mux;
   zynq_shell_pkg::axil_data_t rd_data_r;
   logic                       rd_v_r;

   // only the three low words are writable, the profiler words ignore writes
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         reset_r <= '0;
         alloc_r <= '0;
         base_r  <= '0;
      end
      else if (csr_wr_v_i)
      begin
         case (csr_wr_addr_i)
            zynq_shell_pkg::csr_reset_lp:      reset_r <= csr_wr_data_i;
            zynq_shell_pkg::csr_dram_alloc_lp: alloc_r <= csr_wr_data_i;
            zynq_shell_pkg::csr_dram_base_lp:  base_r  <= csr_wr_data_i;
            default:                           ;
         endcase
      end
   end

   // the core sits in reset until software sets bit 0, and again whenever the
   // shell itself is reset, so a new program can start without a new bitstream
   assign core_reset_o = ~rst_n_i | ~reset_r[0];

   assign dram_base_o = base_r;

   always_comb
   begin
      rd_mux = '0;
      case (csr_rd_addr_i)
         zynq_shell_pkg::csr_reset_lp:      rd_mux = reset_r;
         zynq_shell_pkg::csr_dram_alloc_lp: rd_mux = alloc_r;
         zynq_shell_pkg::csr_dram_base_lp:  rd_mux = base_r;
         default:
         begin
            // profiler banks follow the base register in index order
            for (int b = 0; b < zynq_shell_pkg::num_banks_lp; b++)
            begin
               if (csr_rd_addr_i == zynq_shell_pkg::csr_prof0_lp + b)
               begin
                  rd_mux = prof_words_i[b];
               end
            end
         end
      endcase
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         rd_v_r <= 1'b0;
      end
      else
      begin
         rd_v_r <= csr_rd_v_i;
      end
   end

   // the selected word is captured on each read strobe and held between reads
   always_ff @(posedge aclk_i)
   begin
      if (csr_rd_v_i)
      begin
         rd_data_r <= rd_mux;
      end
   end

   assign csr_rd_data_o = rd_data_r;
   assign csr_rd_v_o    = rd_v_r;

   // every response pulse answers a strobe from the cycle before
   a_rd_resp_follows_strobe: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      !csr_rd_v_i |=> !csr_rd_v_o);

endmodule

/* design/zynq_addr_remap.sv */
module zynq_addr_remap
  (input  logic                       aclk_i

   , input  zynq_shell_pkg::host_addr_t host_awaddr_i
   , input  zynq_shell_pkg::host_addr_t host_araddr_i
   , output zynq_shell_pkg::bp_addr_t   bp_host_awaddr_o
   , output zynq_shell_pkg::bp_addr_t   bp_host_araddr_o

   , input  logic                       dram_awvalid_i
   , input  zynq_shell_pkg::bp_addr_t   dram_awaddr_i
   , input  logic                       dram_arvalid_i
   , input  zynq_shell_pkg::bp_addr_t   dram_araddr_i
   , input  zynq_shell_pkg::bp_addr_t   dram_base_i

   , output zynq_shell_pkg::bp_addr_t   m00_awaddr_o
   , output zynq_shell_pkg::bp_addr_t   m00_araddr_o
   , output logic                       dram_range_err_o
   );

   zynq_shell_pkg::bp_addr_t aw_offset;
   zynq_shell_pkg::bp_addr_t ar_offset;

   // GP1 window 0x0xxx_xxxx lands on processor DRAM at 0x8xxx_xxxx, and
   // 0x2xxx_xxxx lands on the processor's local space at 0x0xxx_xxxx
   assign bp_host_awaddr_o = {~host_awaddr_i[29], 3'b000, host_awaddr_i[27:0]};
   assign bp_host_araddr_o = {~host_araddr_i[29], 3'b000, host_araddr_i[27:0]};

   // xor removes the processor DRAM base since it is a single aligned bit
   assign aw_offset = dram_awaddr_i ^ zynq_shell_pkg::bp_dram_base_lp;
   assign ar_offset = dram_araddr_i ^ zynq_shell_pkg::bp_dram_base_lp;

   // then the offset moves into the block that Linux allocated on the ARM side
   assign m00_awaddr_o = aw_offset + dram_base_i;
   assign m00_araddr_o = ar_offset + dram_base_i;

   // a request past the allocation is flagged, not blocked
   assign dram_range_err_o = (dram_awvalid_i && (aw_offset >= zynq_shell_pkg::dram_limit_lp))
                           | (dram_arvalid_i && (ar_offset >= zynq_shell_pkg::dram_limit_lp));

   // the window translation leaves the 256 MiB page offset alone and
   // always clears the three bits between it and the window select
   a_host_offset_kept: assert property (@(posedge aclk_i)
      !$isunknown({host_awaddr_i, host_araddr_i}) |->
         (bp_host_awaddr_o[27:0] == host_awaddr_i[27:0])
         && (bp_host_araddr_o[27:0] == host_araddr_i[27:0])
         && (bp_host_awaddr_o[30:28] == 3'b000)
         && (bp_host_araddr_o[30:28] == 3'b000));

endmodule

/* design/mem_region_decoder.sv */
module mem_region_decoder
  (input  logic                                                         dram_awvalid_i
   , input  zynq_shell_pkg::bp_addr_t                                   dram_awaddr_i
   , input  logic                                                       dram_arvalid_i
   , input  zynq_shell_pkg::bp_addr_t                                   dram_araddr_i
   , output zynq_shell_pkg::bank_hits_t [zynq_shell_pkg::num_banks_lp-1:0] bank_hits_o
   );

   localparam int unsigned num_regions_lp =
      zynq_shell_pkg::num_banks_lp * zynq_shell_pkg::bank_width_lp;

   zynq_shell_pkg::region_idx_t aw_region;
   zynq_shell_pkg::region_idx_t ar_region;

   logic [num_regions_lp-1:0] aw_hot;
   logic [num_regions_lp-1:0] ar_hot;
   logic [num_regions_lp-1:0] all_hits;

   // address bits 29 down to 23 pick the 8 MiB region, the DRAM base bit
   // above them is ignored so the map starts at region 0
   assign aw_region = dram_awaddr_i[zynq_shell_pkg::region_lsb_lp
                                    +: zynq_shell_pkg::region_width_lp];
   assign ar_region = dram_araddr_i[zynq_shell_pkg::region_lsb_lp
                                    +: zynq_shell_pkg::region_width_lp];

   // one-hot per channel, zero when the channel is idle
   assign aw_hot = num_regions_lp'(dram_awvalid_i) << aw_region;
   assign ar_hot = num_regions_lp'(dram_arvalid_i) << ar_region;

   // a write and a read may touch two regions in the same cycle
   assign all_hits = aw_hot | ar_hot;

   // bank n carries regions 32n to 32n+31
   always_comb
   begin
      for (int b = 0; b < zynq_shell_pkg::num_banks_lp; b++)
      begin
         bank_hits_o[b] = all_hits[b*zynq_shell_pkg::bank_width_lp
                                   +: zynq_shell_pkg::bank_width_lp];
      end
   end

endmodule

/* design/mem_profile_bank.sv */
module mem_profile_bank
  (input  logic                       aclk_i
   , input  logic                     rst_n_i
   , input  logic                     clear_i
   , input  zynq_shell_pkg::bank_hits_t hits_i
   , output zynq_shell_pkg::bank_hits_t touched_o
   );

   zynq_shell_pkg::bank_hits_t touched_r;

   // bits are sticky for the whole run of a program and only a core reset
   // starts the count over
   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         touched_r <= '0;
      end
      else if (clear_i)
      begin
         touched_r <= '0;
      end
      else
      begin
         touched_r <= touched_r | hits_i;
      end
   end

   assign touched_o = touched_r;

   // without a clear, a region once marked stays marked
   a_no_falling_bit: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      !clear_i |=> ((touched_o & $past(touched_o)) == $past(touched_o)));

endmodule

/* design/zynq_shell_top.sv */
module zynq_shell_top
  (input  logic                       aclk_i
   , input  logic                     rst_n_i

   // register port from the ARM side
   , input  logic                       csr_wr_v_i
   , input  zynq_shell_pkg::csr_addr_t  csr_wr_addr_i
   , input  zynq_shell_pkg::axil_data_t csr_wr_data_i
   , input  logic                       csr_rd_v_i
   , input  zynq_shell_pkg::csr_addr_t  csr_rd_addr_i
   , output zynq_shell_pkg::axil_data_t csr_rd_data_o
   , output logic                       csr_rd_v_o

   // GP1 host window
   , input  zynq_shell_pkg::host_addr_t host_awaddr_i
   , input  zynq_shell_pkg::host_addr_t host_araddr_i
   , output zynq_shell_pkg::bp_addr_t   bp_host_awaddr_o
   , output zynq_shell_pkg::bp_addr_t   bp_host_araddr_o

   // DRAM requests from the processor and their relocated addresses
   , input  logic                       dram_awvalid_i
   , input  zynq_shell_pkg::bp_addr_t   dram_awaddr_i
   , input  logic                       dram_arvalid_i
   , input  zynq_shell_pkg::bp_addr_t   dram_araddr_i
   , output zynq_shell_pkg::bp_addr_t   m00_awaddr_o
   , output zynq_shell_pkg::bp_addr_t   m00_araddr_o

   , output logic                       dram_range_err_o
   , output logic                       core_reset_o
   );

   zynq_shell_pkg::bp_addr_t                                    dram_base;
   logic                                                        core_reset;
   zynq_shell_pkg::bank_hits_t [zynq_shell_pkg::num_banks_lp-1:0] bank_hits;
   zynq_shell_pkg::bank_hits_t [zynq_shell_pkg::num_banks_lp-1:0] prof_words;

   zynq_addr_remap i_remap
     (.aclk_i           (aclk_i)
      ,.host_awaddr_i   (host_awaddr_i)
      ,.host_araddr_i   (host_araddr_i)
      ,.bp_host_awaddr_o(bp_host_awaddr_o)
      ,.bp_host_araddr_o(bp_host_araddr_o)
      ,.dram_awvalid_i  (dram_awvalid_i)
      ,.dram_awaddr_i   (dram_awaddr_i)
      ,.dram_arvalid_i  (dram_arvalid_i)
      ,.dram_araddr_i   (dram_araddr_i)
      ,.dram_base_i     (dram_base)
      ,.m00_awaddr_o    (m00_awaddr_o)
      ,.m00_araddr_o    (m00_araddr_o)
      ,.dram_range_err_o(dram_range_err_o)
      );

   // the profiler watches the processor-side addresses before relocation
   mem_region_decoder i_decoder
     (.dram_awvalid_i(dram_awvalid_i)
      ,.dram_awaddr_i (dram_awaddr_i)
      ,.dram_arvalid_i(dram_arvalid_i)
      ,.dram_araddr_i (dram_araddr_i)
      ,.bank_hits_o   (bank_hits)
      );

   for (genvar b = 0; b < zynq_shell_pkg::num_banks_lp; b++)
   begin : g_bank
      mem_profile_bank i_bank
        (.aclk_i    (aclk_i)
         ,.rst_n_i  (rst_n_i)
         ,.clear_i  (core_reset)
         ,.hits_i   (bank_hits[b])
         ,.touched_o(prof_words[b])
         );
   end

   shell_csr_file i_csr
     (.aclk_i        (aclk_i)
      ,.rst_n_i      (rst_n_i)
      ,.csr_wr_v_i   (csr_wr_v_i)
      ,.csr_wr_addr_i(csr_wr_addr_i)
      ,.csr_wr_data_i(csr_wr_data_i)
      ,.csr_rd_v_i   (csr_rd_v_i)
      ,.csr_rd_addr_i(csr_rd_addr_i)
      ,.csr_rd_data_o(csr_rd_data_o)
      ,.csr_rd_v_o   (csr_rd_v_o)
      ,.prof_words_i (prof_words)
      ,.dram_base_o  (dram_base)
      ,.core_reset_o (core_reset)
      );

   assign core_reset_o = core_reset;

endmodule

/* verif/tb_zynq_shell.sv */
module tb_zynq_shell;

   localparam int read_timeout_lp = 20;

   logic                       aclk;
   logic                       rst_n;
   logic                       csr_wr_v;
   zynq_shell_pkg::csr_addr_t  csr_wr_addr;
   zynq_shell_pkg::axil_data_t csr_wr_data;
   logic                       csr_rd_v;
   zynq_shell_pkg::csr_addr_t  csr_rd_addr;
   zynq_shell_pkg::axil_data_t csr_rd_data;
   logic                       csr_rd_resp_v;
   zynq_shell_pkg::host_addr_t host_awaddr;
   zynq_shell_pkg::host_addr_t host_araddr;
   zynq_shell_pkg::bp_addr_t   bp_host_awaddr;
   zynq_shell_pkg::bp_addr_t   bp_host_araddr;
   logic                       dram_awvalid;
   zynq_shell_pkg::bp_addr_t   dram_awaddr;
   logic                       dram_arvalid;
   zynq_shell_pkg::bp_addr_t   dram_araddr;
   zynq_shell_pkg::bp_addr_t   m00_awaddr;
   zynq_shell_pkg::bp_addr_t   m00_araddr;
   logic                       dram_range_err;
   logic                       core_reset;

   // model state, expected read responses and run bookkeeping
   logic [31:0]                rng;
   logic [127:0]               prof_model;
   logic                       core_run;
   zynq_shell_pkg::axil_data_t exp_alloc;
   zynq_shell_pkg::axil_data_t exp_base;
   zynq_shell_pkg::axil_data_t exp_data_q[$];
   int                         exp_cyc_q[$];
   int                         cyc;
   string                      cur_test;
   int                         err_count;
   int                         check_count;
   int                         test_errs_at_start;
   int                         pass_count;
   int                         fail_count;

   zynq_shell_top i_dut
     (.aclk_i           (aclk)
      ,.rst_n_i         (rst_n)
      ,.csr_wr_v_i      (csr_wr_v)
      ,.csr_wr_addr_i   (csr_wr_addr)
      ,.csr_wr_data_i   (csr_wr_data)
      ,.csr_rd_v_i      (csr_rd_v)
      ,.csr_rd_addr_i   (csr_rd_addr)
      ,.csr_rd_data_o   (csr_rd_data)
      ,.csr_rd_v_o      (csr_rd_resp_v)
      ,.host_awaddr_i   (host_awaddr)
      ,.host_araddr_i   (host_araddr)
      ,.bp_host_awaddr_o(bp_host_awaddr)
      ,.bp_host_araddr_o(bp_host_araddr)
      ,.dram_awvalid_i  (dram_awvalid)
      ,.dram_awaddr_i   (dram_awaddr)
      ,.dram_arvalid_i  (dram_arvalid)
      ,.dram_araddr_i   (dram_araddr)
      ,.m00_awaddr_o    (m00_awaddr)
      ,.m00_araddr_o    (m00_araddr)
      ,.dram_range_err_o(dram_range_err)
      ,.core_reset_o    (core_reset)
      );

   always #50 aclk = ~aclk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // bit 31 is the inverted window select, bits 30 to 28 are cleared
   function automatic zynq_shell_pkg::bp_addr_t translate_host(input zynq_shell_pkg::host_addr_t a);
      logic [31:0] r;
      r = {2'b00, a} & 32'h0fff_ffff;
      r[31] = ~a[29];
      return r;
   endfunction

   function automatic zynq_shell_pkg::bp_addr_t relocate_dram(input zynq_shell_pkg::bp_addr_t a,
                                                              input zynq_shell_pkg::bp_addr_t base);
      return (a ^ zynq_shell_pkg::bp_dram_base_lp) + base;
   endfunction

   function automatic logic range_exceeded(input logic awv, input zynq_shell_pkg::bp_addr_t awa,
                                           input logic arv, input zynq_shell_pkg::bp_addr_t ara);
      logic aw_out;
      logic ar_out;
      aw_out = awv && ((awa ^ zynq_shell_pkg::bp_dram_base_lp) >= zynq_shell_pkg::dram_limit_lp);
      ar_out = arv && ((ara ^ zynq_shell_pkg::bp_dram_base_lp) >= zynq_shell_pkg::dram_limit_lp);
      return aw_out || ar_out;
   endfunction

   // each valid request marks the 8 MiB region picked by address bits 29 to 23
   function automatic logic [127:0] mark_regions(input logic [127:0] model,
                                                 input logic awv, input zynq_shell_pkg::bp_addr_t awa,
                                                 input logic arv, input zynq_shell_pkg::bp_addr_t ara);
      logic [127:0] m;
      m = model;
      if (awv)
      begin
         m[awa[29:23]] = 1'b1;
      end
      if (arv)
      begin
         m[ara[29:23]] = 1'b1;
      end
      return m;
   endfunction

   // about half of the picks land within twice the limit, so both sides of it get exercised
   function automatic zynq_shell_pkg::bp_addr_t pick_dram_addr();
      logic [31:0] sel;
      sel = next_rand();
      if (sel[0])
      begin
         return zynq_shell_pkg::bp_dram_base_lp | (next_rand() % (zynq_shell_pkg::dram_limit_lp * 2));
      end
      return next_rand();
   endfunction

   // responses are due on the second falling edge after the strobe's rising edge
   always @(negedge aclk)
   begin
      cyc = cyc + 1;
      if (rst_n && csr_rd_resp_v)
      begin
         if (exp_data_q.size() == 0)
         begin
            $display("error in %s: read response arrived with no read pending", cur_test);
            err_count++;
         end
         else
         begin
            check_count += 2;
            if (csr_rd_data !== exp_data_q[0])
            begin
               $display("mismatch %s read data expected %h actual %h",
                        cur_test, exp_data_q[0], csr_rd_data);
               err_count++;
            end
            if (cyc != exp_cyc_q[0])
            begin
               $display("mismatch %s read response cycle expected %0d actual %0d",
                        cur_test, exp_cyc_q[0], cyc);
               err_count++;
            end
            void'(exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
         end
      end
   end

   task automatic start_test(input string name);
      cur_test = name;
      test_errs_at_start = err_count;
   endtask

   task automatic finish_test();
      if (err_count == test_errs_at_start)
      begin
         pass_count++;
         $display("test %s passed", cur_test);
      end
      else
      begin
         fail_count++;
         $display("test %s failed with %0d errors", cur_test, err_count - test_errs_at_start);
      end
   endtask

   task automatic write_csr(input zynq_shell_pkg::csr_addr_t addr,
                            input zynq_shell_pkg::axil_data_t data);
      @(posedge aclk);
      csr_wr_v    <= 1'b1;
      csr_wr_addr <= addr;
      csr_wr_data <= data;
      @(posedge aclk);
      csr_wr_v    <= 1'b0;
      if (addr == zynq_shell_pkg::csr_reset_lp)
      begin
         core_run = data[0];
         // the core reset clears every bank on the following edges
         if (!data[0])
         begin
            prof_model = '0;
         end
      end
   endtask

   task automatic issue_read(input zynq_shell_pkg::csr_addr_t addr,
                             input zynq_shell_pkg::axil_data_t expected);
      @(posedge aclk);
      csr_rd_v    <= 1'b1;
      csr_rd_addr <= addr;
      exp_data_q.push_back(expected);
      exp_cyc_q.push_back(cyc + 2);
   endtask

   task automatic drain_reads();
      int waited;
      waited = 0;
      @(posedge aclk);
      csr_rd_v <= 1'b0;
      while (exp_data_q.size() != 0 && waited < read_timeout_lp)
      begin
         @(posedge aclk);
         waited++;
      end
      if (exp_data_q.size() != 0)
      begin
         $display("error in %s: read response still missing after %0d cycles",
                  cur_test, read_timeout_lp);
         $display("TEST FAIL");
         $finish;
      end
   endtask

   task automatic check_dram_cycle(input logic awv, input zynq_shell_pkg::bp_addr_t awa,
                                   input logic arv, input zynq_shell_pkg::bp_addr_t ara);
      zynq_shell_pkg::bp_addr_t exp_aw;
      zynq_shell_pkg::bp_addr_t exp_ar;
      logic                     exp_err;
      exp_aw  = relocate_dram(awa, exp_base);
      exp_ar  = relocate_dram(ara, exp_base);
      exp_err = range_exceeded(awv, awa, arv, ara);
      @(posedge aclk);
      dram_awvalid <= awv;
      dram_awaddr  <= awa;
      dram_arvalid <= arv;
      dram_araddr  <= ara;
      if (core_run)
      begin
         prof_model = mark_regions(prof_model, awv, awa, arv, ara);
      end
      @(negedge aclk);
      check_count += 3;
      if (m00_awaddr !== exp_aw)
      begin
         $display("mismatch %s m00_awaddr expected %h actual %h", cur_test, exp_aw, m00_awaddr);
         err_count++;
      end
      if (m00_araddr !== exp_ar)
      begin
         $display("mismatch %s m00_araddr expected %h actual %h", cur_test, exp_ar, m00_araddr);
         err_count++;
      end
      if (dram_range_err !== exp_err)
      begin
         $display("mismatch %s dram_range_err expected %b actual %b",
                  cur_test, exp_err, dram_range_err);
         err_count++;
      end
   endtask

   task automatic set_dram_idle();
      @(posedge aclk);
      dram_awvalid <= 1'b0;
      dram_arvalid <= 1'b0;
   endtask

   initial
   begin
      logic [31:0]                r;
      zynq_shell_pkg::host_addr_t host_a;
      zynq_shell_pkg::host_addr_t host_b;
      zynq_shell_pkg::bp_addr_t   addr_a;
      zynq_shell_pkg::bp_addr_t   addr_b;
      zynq_shell_pkg::bp_addr_t   below_limit;
      zynq_shell_pkg::bp_addr_t   at_limit;

      aclk         = 1'b0;
      rst_n        = 1'b0;
      csr_wr_v     = 1'b0;
      csr_wr_addr  = '0;
      csr_wr_data  = '0;
      csr_rd_v     = 1'b0;
      csr_rd_addr  = '0;
      host_awaddr  = '0;
      host_araddr  = '0;
      dram_awvalid = 1'b0;
      dram_awaddr  = '0;
      dram_arvalid = 1'b0;
      dram_araddr  = '0;
      rng          = 32'h8cc2;
      prof_model   = '0;
      core_run     = 1'b0;
      exp_alloc    = '0;
      exp_base     = '0;
      cyc          = 0;
      err_count    = 0;
      check_count  = 0;
      pass_count   = 0;
      fail_count   = 0;
      cur_test     = "reset";

      repeat (16) @(posedge aclk);
      rst_n <= 1'b1;

      start_test("reset_state");
      @(negedge aclk);
      check_count += 2;
      if (core_reset !== 1'b1)
      begin
         $display("mismatch %s core_reset expected 1 actual %b", cur_test, core_reset);
         err_count++;
      end
      if (csr_rd_resp_v !== 1'b0)
      begin
         $display("mismatch %s csr_rd_v expected 0 actual %b", cur_test, csr_rd_resp_v);
         err_count++;
      end
      // back to back reads over the whole map, index 7 included
      for (int i = 0; i < 8; i++)
      begin
         issue_read(zynq_shell_pkg::csr_addr_t'(i), '0);
      end
      drain_reads();
      finish_test();

      start_test("register_access");
      exp_alloc = next_rand();
      exp_base  = next_rand();
      write_csr(zynq_shell_pkg::csr_reset_lp, 32'h1);
      @(negedge aclk);
      check_count++;
      if (core_reset !== 1'b0)
      begin
         $display("mismatch %s core_reset expected 0 actual %b", cur_test, core_reset);
         err_count++;
      end
      write_csr(zynq_shell_pkg::csr_dram_alloc_lp, exp_alloc);
      write_csr(zynq_shell_pkg::csr_dram_base_lp, exp_base);
      write_csr(3'd4, next_rand());
      issue_read(zynq_shell_pkg::csr_reset_lp, 32'h1);
      issue_read(zynq_shell_pkg::csr_dram_alloc_lp, exp_alloc);
      issue_read(zynq_shell_pkg::csr_dram_base_lp, exp_base);
      issue_read(3'd4, prof_model[63:32]);
      drain_reads();
      finish_test();

      start_test("host_window");
      for (int i = 0; i < 32; i++)
      begin
         r      = next_rand();
         host_a = r[29:0];
         r      = next_rand();
         host_b = r[29:0];
         @(posedge aclk);
         host_awaddr <= host_a;
         host_araddr <= host_b;
         @(negedge aclk);
         check_count += 2;
         if (bp_host_awaddr !== translate_host(host_a))
         begin
            $display("mismatch %s bp_host_awaddr expected %h actual %h",
                     cur_test, translate_host(host_a), bp_host_awaddr);
            err_count++;
         end
         if (bp_host_araddr !== translate_host(host_b))
         begin
            $display("mismatch %s bp_host_araddr expected %h actual %h",
                     cur_test, translate_host(host_b), bp_host_araddr);
            err_count++;
         end
      end
      finish_test();

      start_test("dram_relocation");
      exp_base = next_rand();
      write_csr(zynq_shell_pkg::csr_dram_base_lp, exp_base);
      for (int i = 0; i < 48; i++)
      begin
         r      = next_rand();
         addr_a = pick_dram_addr();
         addr_b = pick_dram_addr();
         check_dram_cycle(r[0], addr_a, r[1], addr_b);
      end
      // the last legal offset and the first illegal one, on each channel
      below_limit = zynq_shell_pkg::bp_dram_base_lp | (zynq_shell_pkg::dram_limit_lp - 1);
      at_limit    = zynq_shell_pkg::bp_dram_base_lp | zynq_shell_pkg::dram_limit_lp;
      check_dram_cycle(1'b1, below_limit, 1'b0, at_limit);
      check_dram_cycle(1'b1, at_limit, 1'b0, below_limit);
      check_dram_cycle(1'b0, at_limit, 1'b1, below_limit);
      check_dram_cycle(1'b1, below_limit, 1'b1, at_limit);
      set_dram_idle();
      finish_test();

      start_test("mem_profiler");
      for (int i = 0; i < 64; i++)
      begin
         r      = next_rand();
         addr_a = next_rand();
         addr_b = next_rand();
         check_dram_cycle(r[0], addr_a, r[1], addr_b);
      end
      set_dram_idle();
      for (int b = 0; b < 4; b++)
      begin
         issue_read(zynq_shell_pkg::csr_addr_t'(zynq_shell_pkg::csr_prof0_lp + b),
                    prof_model[32*b +: 32]);
      end
      drain_reads();
      // pulsing the core reset starts the profile over
      write_csr(zynq_shell_pkg::csr_reset_lp, 32'h0);
      write_csr(zynq_shell_pkg::csr_reset_lp, 32'h1);
      for (int b = 0; b < 4; b++)
      begin
         issue_read(zynq_shell_pkg::csr_addr_t'(zynq_shell_pkg::csr_prof0_lp + b),
                    prof_model[32*b +: 32]);
      end
      drain_reads();
      finish_test();

      $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
               pass_count, fail_count, check_count, err_count);
      if (fail_count == 0 && err_count == 0 && exp_data_q.size() == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* flist.f */
design/zynq_shell_pkg.sv
design/shell_csr_file.sv
design/zynq_addr_remap.sv
design/mem_region_decoder.sv
design/mem_profile_bank.sv
design/zynq_shell_top.sv
verif/tb_zynq_shell.sv

/* Bender.yml */
package:
  name: zynq_shell

sources:
  # package first, then the leaf modules, then the top level
  - design/zynq_shell_pkg.sv
  - design/shell_csr_file.sv
  - design/zynq_addr_remap.sv
  - design/mem_region_decoder.sv
  - design/mem_profile_bank.sv
  - design/zynq_shell_top.sv

  # testbench with top module tb_zynq_shell
  - target: simulation
    files:
      - verif/tb_zynq_shell.sv
